//--- hdl/chip_pkg.sv
/*
 * Shared constants and enums for the SPI-to-RAM chip subsystem.
 * Imported by the RTL modules and by the testbench.
 */
package chip_pkg;

  // RAM geometry
  localparam int RAM_AW = 14;
  localparam int DATA_W = 32;

  // SPI frame layout, in bits per phase
  localparam int OP_BITS   = 8;
  localparam int ADDR_BITS = 16;
  localparam int BIT_CNT_W = 5;

  // special word addresses watched by the status monitor
  localparam logic [RAM_AW-1:0] SW_STATUS_ADDR = 14'h3ff0;
  localparam logic [RAM_AW-1:0] SW_LOG_ADDR    = 14'h3ff1;

  // command opcodes, anything else is ignored by the slave
  typedef enum logic [7:0] {
    OP_WRITE = 8'h02,
    OP_READ  = 8'h03
  } spi_op_e;

  // frame phase of the SPI command slave
  typedef enum logic [1:0] {
    ST_OPCODE,
    ST_ADDR,
    ST_DATA,
    ST_IGNORE
  } spi_state_e;

  // test status codes, carried in the low 16 bits of the status word
  typedef enum logic [15:0] {
    STATUS_IN_BOOT_ROM = 16'hb090,
    STATUS_IN_TEST     = 16'h4354,
    STATUS_PASSED      = 16'h900d,
    STATUS_FAILED      = 16'hbaad
  } sw_status_e;

endpackage

//--- hdl/spi_cmd_slave.sv
/*
 * SPI mode 0 command slave. Receives opcode, address and data frames
 * from the host and turns them into single-cycle RAM requests.
 * Read data is shifted back out on sdo, MSB first.
 */
`timescale 1ns/1ps

module spi_cmd_slave import chip_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              sck_i,
  input  logic              csb_i,
  input  logic              sdi_i,
  input  logic [DATA_W-1:0] rdata_i,
  output logic              sdo_o,
  output logic              req_o,
  output logic              write_o,
  output logic [RAM_AW-1:0] addr_o,
  output logic [DATA_W-1:0] wdata_o
);

  // two-flop synchronizers for the pins
  logic [1:0] sck_sync_q;
  logic [1:0] csb_sync_q;
  logic [1:0] sdi_sync_q;
  logic       sck_prev_q;

  logic sck_s;
  logic csb_s;
  logic sdi_s;
  logic sck_rise;
  logic sck_fall;

  spi_state_e           state_q;
  spi_op_e              op_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [BIT_CNT_W-1:0] cnt_last;
  logic                 phase_done;

  logic              req_q;
  logic              write_q;
  logic              rd_load_q;
  logic              sdo_q;
  logic [DATA_W-1:0] in_sr_q;
  logic [DATA_W-1:0] shift_next;
  logic [DATA_W-1:0] out_sr_q;
  logic [RAM_AW-1:0] addr_q;
  logic              shift_out;

  assign sck_s = sck_sync_q[1];
  assign csb_s = csb_sync_q[1];
  assign sdi_s = sdi_sync_q[1];

  assign sck_rise = sck_s & ~sck_prev_q;
  assign sck_fall = ~sck_s & sck_prev_q;

  assign shift_next = {in_sr_q[DATA_W-2:0], sdi_s};

  // last bit index of the current phase
  always_comb begin
    case (state_q)
      ST_OPCODE: cnt_last = BIT_CNT_W'(OP_BITS - 1);
      ST_ADDR:   cnt_last = BIT_CNT_W'(ADDR_BITS - 1);
      default:   cnt_last = BIT_CNT_W'(DATA_W - 1);
    endcase
  end

  assign phase_done = (cnt_q == cnt_last);

  // only read frames drive sdo, and only in the data phase
  assign shift_out = sck_fall && !csb_s && state_q == ST_DATA && op_q == OP_READ;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_sync_q <= 2'b00;
      csb_sync_q <= 2'b11;
      sdi_sync_q <= 2'b00;
      sck_prev_q <= 1'b0;
      state_q    <= ST_OPCODE;
      op_q       <= OP_READ;
      cnt_q      <= '0;
      req_q      <= 1'b0;
      write_q    <= 1'b0;
      rd_load_q  <= 1'b0;
      sdo_q      <= 1'b0;
    end else begin
      sck_sync_q <= {sck_sync_q[0], sck_i};
      csb_sync_q <= {csb_sync_q[0], csb_i};
      sdi_sync_q <= {sdi_sync_q[0], sdi_i};
      sck_prev_q <= sck_s;

      req_q     <= 1'b0;
      write_q   <= 1'b0;
      // rdata is valid the cycle after a read request
      rd_load_q <= req_q & ~write_q;

      if (csb_s) begin
        // idle or aborted frame
        state_q <= ST_OPCODE;
        cnt_q   <= '0;
        sdo_q   <= 1'b0;
      end else begin
        if (sck_rise && state_q != ST_IGNORE) begin
          cnt_q <= phase_done ? '0 : cnt_q + 1'b1;
          if (phase_done) begin
            case (state_q)
              ST_OPCODE: begin
                if (shift_next[OP_BITS-1:0] == OP_WRITE ||
                    shift_next[OP_BITS-1:0] == OP_READ) begin
                  op_q    <= spi_op_e'(shift_next[OP_BITS-1:0]);
                  state_q <= ST_ADDR;
                end else begin
                  state_q <= ST_IGNORE;
                end
              end
              ST_ADDR: begin
                state_q <= ST_DATA;
                if (op_q == OP_READ) begin
                  req_q <= 1'b1;
                end
              end
              ST_DATA: begin
                state_q <= ST_IGNORE;
                if (op_q == OP_WRITE) begin
                  req_q   <= 1'b1;
                  write_q <= 1'b1;
                end
              end
              default: state_q <= ST_IGNORE;
            endcase
          end
        end
        if (shift_out) begin
          sdo_q <= out_sr_q[DATA_W-1];
        end
      end
    end
  end

  // payload shift registers
  always_ff @(posedge clk) begin
    if (sck_rise && !csb_s) begin
      in_sr_q <= shift_next;
      if (state_q == ST_ADDR && phase_done) begin
        addr_q <= shift_next[RAM_AW-1:0];
      end
    end
    if (rd_load_q) begin
      out_sr_q <= rdata_i;
    end else if (shift_out) begin
      out_sr_q <= {out_sr_q[DATA_W-2:0], 1'b0};
    end
  end

  assign sdo_o   = sdo_q;
  assign req_o   = req_q;
  assign write_o = write_q;
  assign addr_o  = addr_q;
  assign wdata_o = in_sr_q;

  // one request per frame, never back to back
  a_req_pulse: assert property (@(posedge clk) disable iff (rst_i) req_o |=> !req_o);

  a_write_with_req: assert property (@(posedge clk) disable iff (rst_i) write_o |-> req_o);

endmodule

//--- hdl/ram_main.sv
/*
 * Main single-port word RAM. Writes complete in the request cycle,
 * read data is registered and valid one clock after the request.
 */
`timescale 1ns/1ps

module ram_main import chip_pkg::*; (
  input  logic              clk,
  input  logic              req_i,
  input  logic              write_i,
  input  logic [RAM_AW-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int DEPTH = 2 ** RAM_AW;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DATA_W-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (req_i) begin
      if (write_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        // registered read port
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/sw_status_mon.sv
/*
 * Software status monitor. Snoops RAM write requests to the test-status
 * and software-log words and reports them on chip outputs.
 */
`timescale 1ns/1ps

module sw_status_mon import chip_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              req_i,
  input  logic              write_i,
  input  logic [RAM_AW-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output sw_status_e        status_o,
  output logic              test_done_o,
  output logic              test_passed_o,
  output logic              log_valid_o,
  output logic [DATA_W-1:0] log_data_o
);

  logic wr_req;
  logic status_hit;
  logic log_hit;

  sw_status_e        status_q;
  logic              done_q;
  logic              passed_q;
  logic              log_valid_q;
  logic [DATA_W-1:0] log_data_q;

  assign wr_req     = req_i & write_i;
  assign status_hit = wr_req && addr_i == SW_STATUS_ADDR;
  assign log_hit    = wr_req && addr_i == SW_LOG_ADDR;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      status_q    <= STATUS_IN_BOOT_ROM;
      done_q      <= 1'b0;
      passed_q    <= 1'b0;
      log_valid_q <= 1'b0;
    end else begin
      log_valid_q <= log_hit;
      if (status_hit) begin
        // unknown codes leave everything as it was
        case (wdata_i[15:0])
          STATUS_IN_BOOT_ROM: begin
            status_q <= STATUS_IN_BOOT_ROM;
          end
          STATUS_IN_TEST: begin
            status_q <= STATUS_IN_TEST;
            done_q   <= 1'b0;
            passed_q <= 1'b0;
          end
          STATUS_PASSED: begin
            status_q <= STATUS_PASSED;
            done_q   <= 1'b1;
            passed_q <= 1'b1;
          end
          STATUS_FAILED: begin
            status_q <= STATUS_FAILED;
            done_q   <= 1'b1;
            passed_q <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  // log word held until the next log write
  always_ff @(posedge clk) begin
    if (log_hit) begin
      log_data_q <= wdata_i;
    end
  end

  assign status_o      = status_q;
  assign test_done_o   = done_q;
  assign test_passed_o = passed_q;
  assign log_valid_o   = log_valid_q;
  assign log_data_o    = log_data_q;

  a_passed_is_done: assert property (@(posedge clk) disable iff (rst_i)
    test_passed_o |-> test_done_o);

endmodule

//--- hdl/chip_top.sv
/*
 * Chip top level. The SPI command slave drives the main RAM, and the
 * status monitor snoops the same request port.
 */
`timescale 1ns/1ps

module chip_top import chip_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              spi_sck_i,
  input  logic              spi_csb_i,
  input  logic              spi_sdi_i,
  output logic              spi_sdo_o,
  output logic              test_done_o,
  output logic              test_passed_o,
  output sw_status_e        status_o,
  output logic              log_valid_o,
  output logic [DATA_W-1:0] log_data_o
);

  // RAM request port, shared by the RAM and the monitor
  logic              ram_req;
  logic              ram_write;
  logic [RAM_AW-1:0] ram_addr;
  logic [DATA_W-1:0] ram_wdata;
  logic [DATA_W-1:0] ram_rdata;

  spi_cmd_slave u_spi_cmd_slave (
    .clk     (clk),
    .rst_i   (rst_i),
    .sck_i   (spi_sck_i),
    .csb_i   (spi_csb_i),
    .sdi_i   (spi_sdi_i),
    .rdata_i (ram_rdata),
    .sdo_o   (spi_sdo_o),
    .req_o   (ram_req),
    .write_o (ram_write),
    .addr_o  (ram_addr),
    .wdata_o (ram_wdata)
  );

  ram_main u_ram_main (
    .clk     (clk),
    .req_i   (ram_req),
    .write_i (ram_write),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  sw_status_mon u_sw_status_mon (
    .clk           (clk),
    .rst_i         (rst_i),
    .req_i         (ram_req),
    .write_i       (ram_write),
    .addr_i        (ram_addr),
    .wdata_i       (ram_wdata),
    .status_o      (status_o),
    .test_done_o   (test_done_o),
    .test_passed_o (test_passed_o),
    .log_valid_o   (log_valid_o),
    .log_data_o    (log_data_o)
  );

endmodule

//--- tests/tb_chip.sv
/*
 * Directed testbench for chip_top. An SPI host task sends command frames,
 * compare tasks check read data, status outputs and log strobes.
 */
`timescale 1ns/1ps

module tb_chip import chip_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int PHASE_CLKS   = 5;
  localparam int FRAME_BITS   = 56;
  localparam int HDR_BITS     = 24;
  localparam int FRAME_CLKS   = FRAME_BITS * 2 * PHASE_CLKS + 4 * PHASE_CLKS;
  // frames sent by each test, in run order
  localparam int NUM_FRAMES   = 16 + 3 + 3 + 4 + 5;
  localparam int WATCHDOG_NS  = CLK_PERIOD * (RESET_CYCLES + NUM_FRAMES * FRAME_CLKS + 1000);

  logic              clk;
  logic              rst_i;
  logic              sck;
  logic              csb;
  logic              sdi;
  logic              sdo;
  logic              test_done;
  logic              test_passed;
  sw_status_e        status;
  logic              log_valid;
  logic [DATA_W-1:0] log_data;

  int                seed;
  int                log_count;
  logic [DATA_W-1:0] log_seen;

  chip_top UUT (
    .clk           (clk),
    .rst_i         (rst_i),
    .spi_sck_i     (sck),
    .spi_csb_i     (csb),
    .spi_sdi_i     (sdi),
    .spi_sdo_o     (sdo),
    .test_done_o   (test_done),
    .test_passed_o (test_passed),
    .status_o      (status),
    .log_valid_o   (log_valid),
    .log_data_o    (log_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // log strobes counted mid-cycle
  always @(negedge clk) begin
    if (!rst_i && log_valid) begin
      log_count = log_count + 1;
      log_seen  = log_data;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $fatal(1, "simulation timeout");
  end

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_status(input string name, input sw_status_e exp,
                              input sw_status_e act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %s (%h), actual %s (%h)",
               name, exp.name(), exp, act.name(), act);
      $display("*** FAILED ***");
      $fatal(1, "status compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "bit compare failed");
    end
  endtask

  // mode 0 host that sends nbits of the frame and collects sdo in the data phase
  task automatic spi_frame(input logic [7:0] op, input logic [RAM_AW-1:0] addr,
                           input logic [DATA_W-1:0] data, input int nbits,
                           output logic [DATA_W-1:0] rx);
    logic [FRAME_BITS-1:0] frame;
    int                    i;
    frame = {op, 16'(addr), data};
    rx    = '0;
    @(negedge clk);
    csb = 1'b0;
    repeat (PHASE_CLKS) @(negedge clk);
    for (i = 0; i < nbits; i++) begin
      sdi = frame[FRAME_BITS-1-i];
      repeat (PHASE_CLKS) @(negedge clk);
      if (i >= HDR_BITS) begin
        rx = {rx[DATA_W-2:0], sdo};
      end
      sck = 1'b1;
      repeat (PHASE_CLKS) @(negedge clk);
      sck = 1'b0;
    end
    repeat (PHASE_CLKS) @(negedge clk);
    csb = 1'b1;
    sdi = 1'b0;
    repeat (PHASE_CLKS) @(negedge clk);
  endtask

  task automatic write_word(input logic [RAM_AW-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rx;
    spi_frame(OP_WRITE, addr, data, FRAME_BITS, rx);
  endtask

  task automatic read_word(input logic [RAM_AW-1:0] addr, output logic [DATA_W-1:0] data);
    spi_frame(OP_READ, addr, '0, FRAME_BITS, data);
  endtask

  task automatic wait_log(input int expected_count);
    int waited;
    waited = 0;
    while (log_count < expected_count && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (log_count < expected_count) begin
      $display("ERROR: log_valid_o did not pulse within 10 clock cycles after csb rose");
      $display("*** FAILED ***");
      $fatal(1, "missing log strobe");
    end
  endtask

  task automatic reset_values();
    check_bit("reset_state done", 1'b0, test_done);
    check_bit("reset_state passed", 1'b0, test_passed);
    check_bit("reset_state log_valid", 1'b0, log_valid);
    check_bit("reset_state sdo", 1'b0, sdo);
    check_status("reset_state status", STATUS_IN_BOOT_ROM, status);
  endtask

  task automatic ram_round_trip();
    logic [RAM_AW-1:0] addrs [8];
    logic [DATA_W-1:0] model [logic [RAM_AW-1:0]];
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] rdata;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = RAM_AW'($random(seed));
      // keep clear of the monitored words
      if (addrs[i] == SW_STATUS_ADDR || addrs[i] == SW_LOG_ADDR) begin
        addrs[i] = addrs[i] - RAM_AW'(2);
      end
    end
    // one address is written twice so the later word must win
    addrs[7] = addrs[2];
    for (int i = 0; i < 8; i++) begin
      word = $random(seed);
      write_word(addrs[i], word);
      model[addrs[i]] = word;
    end
    for (int i = 0; i < 8; i++) begin
      read_word(addrs[i], rdata);
      check_word("ram_round_trip", model[addrs[i]], rdata);
    end
  endtask

  task automatic status_pass_flow();
    logic [DATA_W-1:0] word;
    word = $random(seed);
    word[15:0] = STATUS_IN_TEST;
    write_word(SW_STATUS_ADDR, word);
    check_status("status_passing in_test", STATUS_IN_TEST, status);
    check_bit("status_passing in_test done", 1'b0, test_done);
    word = $random(seed);
    word[15:0] = STATUS_PASSED;
    write_word(SW_STATUS_ADDR, word);
    check_status("status_passing passed", STATUS_PASSED, status);
    check_bit("status_passing done", 1'b1, test_done);
    check_bit("status_passing passed", 1'b1, test_passed);
    // an unknown code moves nothing
    word = $random(seed);
    word[15:0] = 16'h1234;
    write_word(SW_STATUS_ADDR, word);
    check_status("status_passing unknown", STATUS_PASSED, status);
    check_bit("status_passing unknown done", 1'b1, test_done);
    check_bit("status_passing unknown passed", 1'b1, test_passed);
  endtask

  task automatic status_fail_flow();
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] rdata;
    word = $random(seed);
    word[15:0] = STATUS_IN_TEST;
    write_word(SW_STATUS_ADDR, word);
    check_status("status_failing in_test", STATUS_IN_TEST, status);
    check_bit("status_failing in_test done", 1'b0, test_done);
    check_bit("status_failing in_test passed", 1'b0, test_passed);
    word = $random(seed);
    word[15:0] = STATUS_FAILED;
    write_word(SW_STATUS_ADDR, word);
    check_status("status_failing failed", STATUS_FAILED, status);
    check_bit("status_failing done", 1'b1, test_done);
    check_bit("status_failing passed", 1'b0, test_passed);
    read_word(SW_STATUS_ADDR, rdata);
    check_word("status_failing read_back", word, rdata);
  endtask

  task automatic log_strobes();
    logic [DATA_W-1:0] word;
    int                start;
    start = log_count;
    for (int k = 0; k < 3; k++) begin
      word = $random(seed);
      write_word(SW_LOG_ADDR, word);
      wait_log(start + k + 1);
      check_word("log_strobe count", DATA_W'(start + k + 1), DATA_W'(log_count));
      check_word("log_strobe strobe data", word, log_seen);
      check_word("log_strobe held data", word, log_data);
    end
    write_word(14'h0100, $random(seed));
    check_word("log_strobe other write", DATA_W'(start + 3), DATA_W'(log_count));
  endtask

  task automatic ignored_frames();
    logic [RAM_AW-1:0] addr;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] rx;
    addr = 14'h0a5c;
    word = $random(seed);
    write_word(addr, word);
    spi_frame(8'h5a, addr, ~word, FRAME_BITS, rx);
    read_word(addr, rx);
    check_word("ignored_frames bad_opcode", word, rx);
    // csb rises in the middle of the data phase
    spi_frame(OP_WRITE, addr, ~word, 40, rx);
    read_word(addr, rx);
    check_word("ignored_frames aborted", word, rx);
  endtask

  initial begin
    seed      = 32'hc949;
    clk       = 1'b0;
    rst_i     = 1'b1;
    sck       = 1'b0;
    csb       = 1'b1;
    sdi       = 1'b0;
    log_count = 0;
    log_seen  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_i = 1'b0;
    repeat (2) @(negedge clk);
    reset_values();
    ram_round_trip();
    status_pass_flow();
    status_fail_flow();
    log_strobes();
    ignored_frames();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- all.f
hdl/chip_pkg.sv
hdl/spi_cmd_slave.sv
hdl/ram_main.sv
hdl/sw_status_mon.sv
hdl/chip_top.sv
tests/tb_chip.sv

//--- run.sh
#!/bin/sh
# Builds the chip testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_chip -Mdir obj_dir
out=$(./obj_dir/Vtb_chip 2>&1) || true
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
